/* src/cpuPkg.sv */
`default_nettype none

package cpuPkg;

  typedef logic [15:0] addrT;     // Memory address or PC
  typedef logic [7:0]  dataT;
  typedef logic [6:0]  flowIdxT;  // Microcode ROM address

  typedef enum logic [3:0] {
    uNop,
    uSetAddr,     // Latch address source, raise read request
    uLoadMem,
    uStoreMem,
    uMovReg,
    uAluOp,
    uLoadPcLow,
    uLoadPcHigh,
    uJump
  } uCmdE;

  typedef enum logic [2:0] {
    eofNone,
    eofAlways,
    eofC,
    eofNc,
    eofZ,
    eofNz
  } eofSelE;

  // B..A share the Z80 ordering, so they double as register file indexes
  typedef enum logic [3:0] {
    regB,
    regC,
    regD,
    regE,
    regH,
    regL,
    regA,
    regHl,
    regPc,
    regTmpPc,
    regNone
  } regSelE;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluXor,
    aluOr
  } aluOpE;

  typedef struct packed {
    eofSelE eofSel;
    logic   incPc;
    uCmdE   cmd;
    regSelE operand;
  } uopT;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flagsT;

  typedef struct packed {
    addrT addr;
    dataT wrData;
    logic we;
    logic re;
  } memBusT;

  typedef enum logic [1:0] {
    afterReset,
    startFlow,
    runFlow,
    endFlow
  } seqStateE;

endpackage

`default_nettype wire

/* src/microcodeRom.sv */
`timescale 1ns/1ps
`default_nettype none

module microcodeRom
  import cpuPkg::*;
(
  input  wire dataT    opcode,
  input  wire flowIdxT uPc,
  output flowIdxT      flowStart,
  output uopT          uop
);

  localparam flowIdxT FlowNop     = 7'd0;
  localparam flowIdxT FlowLdImm   = 7'd1;
  localparam flowIdxT FlowLdReg   = 7'd3;
  localparam flowIdxT FlowStoreHl = 7'd4;
  localparam flowIdxT FlowLoadHl  = 7'd6;
  localparam flowIdxT FlowAluReg  = 7'd8;
  localparam flowIdxT FlowAluImm  = 7'd9;
  localparam flowIdxT FlowJp      = 7'd11;
  localparam flowIdxT FlowJpZ     = 7'd15;
  localparam flowIdxT FlowJpNz    = 7'd19;
  localparam flowIdxT FlowJpC     = 7'd23;
  localparam flowIdxT FlowJpNc    = 7'd27;

  logic aluKept;

  // ADD, SUB, AND, XOR, OR only
  assign aluKept = (opcode[5:3] inside {3'b000, 3'b010, 3'b100, 3'b101, 3'b110});

  // ----------------------------------------------------------------------
  // Opcode to flow start
  always_comb
  begin
    flowStart = FlowNop;
    case (opcode[7:6])
      2'b00:
        if (opcode[2:0] == 3'b110 && opcode[5:3] != 3'b110)
          flowStart = FlowLdImm;
      2'b01:
        if (opcode == 8'h77)
          flowStart = FlowStoreHl;
        else if (opcode == 8'h7E)
          flowStart = FlowLoadHl;
        else if (opcode[5:3] != 3'b110 && opcode[2:0] != 3'b110)
          flowStart = FlowLdReg;   // HALT falls through to NOP
      2'b10:
        if (aluKept && opcode[2:0] != 3'b110)
          flowStart = FlowAluReg;
      default:
        if (aluKept && opcode[2:0] == 3'b110)
          flowStart = FlowAluImm;
        else
          case (opcode)
            8'hC3:   flowStart = FlowJp;
            8'hCA:   flowStart = FlowJpZ;
            8'hC2:   flowStart = FlowJpNz;
            8'hDA:   flowStart = FlowJpC;
            8'hD2:   flowStart = FlowJpNc;
            default: flowStart = FlowNop;
          endcase
    endcase
  end

  // ----------------------------------------------------------------------
  // Micro-op store
  // Fields: eofSel, incPc, cmd, operand
  always_comb
  begin
    case (uPc)
      7'd0:  uop = '{eofAlways, 1'b1, uNop, regNone};
      7'd1:  uop = '{eofNone,   1'b1, uNop, regNone};
      7'd2:  uop = '{eofAlways, 1'b1, uLoadMem, regNone};  // Dest from opcode
      7'd3:  uop = '{eofAlways, 1'b1, uMovReg, regNone};
      7'd4:  uop = '{eofNone,   1'b1, uSetAddr, regHl};
      7'd5:  uop = '{eofAlways, 1'b0, uStoreMem, regA};
      7'd6:  uop = '{eofNone,   1'b1, uSetAddr, regHl};
      7'd7:  uop = '{eofAlways, 1'b0, uLoadMem, regA};
      7'd8:  uop = '{eofAlways, 1'b1, uAluOp, regA};
      7'd9:  uop = '{eofNone,   1'b1, uNop, regNone};
      7'd10: uop = '{eofAlways, 1'b1, uAluOp, regA};       // Immediate operand
      // Jump flows differ only in the exit after the high byte
      7'd11, 7'd15, 7'd19, 7'd23, 7'd27:
        uop = '{eofNone, 1'b1, uNop, regNone};
      7'd12, 7'd16, 7'd20, 7'd24, 7'd28:
        uop = '{eofNone, 1'b1, uLoadPcLow, regTmpPc};
      7'd13: uop = '{eofNone, 1'b1, uLoadPcHigh, regTmpPc};
      7'd17: uop = '{eofNz,   1'b1, uLoadPcHigh, regTmpPc};
      7'd21: uop = '{eofZ,    1'b1, uLoadPcHigh, regTmpPc};
      7'd25: uop = '{eofNc,   1'b1, uLoadPcHigh, regTmpPc};
      7'd29: uop = '{eofC,    1'b1, uLoadPcHigh, regTmpPc};
      7'd14, 7'd18, 7'd22, 7'd26, 7'd30:
        uop = '{eofAlways, 1'b0, uJump, regTmpPc};
      default: uop = '{eofAlways, 1'b0, uNop, regNone};
    endcase
  end

endmodule

`default_nettype wire

/* src/flowSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module flowSequencer
  import cpuPkg::*;
#(
  parameter addrT resetPc = 16'h0000
)
(
  input  wire logic    iClock,
  input  wire logic    rstN,
  input  wire dataT    iMemData,
  input  wire uopT     uop,
  input  wire flowIdxT flowStart,
  input  wire flagsT   flags,
  input  wire logic    overwritePc,
  input  wire addrT    target,
  output flowIdxT      uPc,
  output addrT         pc,
  output dataT         opcode,
  output logic         flowEnable,
  output logic         oEof,
  output logic         oBranchTaken
);

  seqStateE state;
  seqStateE nextState;
  flowIdxT  stepQ;
  logic     eofHit;

  // ----------------------------------------------------------------------
  // Flow FSM
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      state <= afterReset;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      afterReset: nextState = startFlow;
      startFlow:  nextState = runFlow;
      runFlow:    nextState = oEof ? endFlow : runFlow;
      default:    nextState = startFlow;
    endcase
  end

  assign flowEnable = (state == runFlow);

  // Opcode latch and step count within the flow
  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      stepQ  <= '0;
      opcode <= '0;
    end
    else if (state == startFlow)
    begin
      stepQ  <= '0;
      opcode <= iMemData;   // Fetched at PC
    end
    else if (flowEnable)
      stepQ <= stepQ + 1'b1;
  end

  assign uPc = flowStart + stepQ;

  always_comb
  begin
    case (uop.eofSel)
      eofAlways: eofHit = 1'b1;
      eofC:      eofHit = flags.c;
      eofNc:     eofHit = ~flags.c;
      eofZ:      eofHit = flags.z;
      eofNz:     eofHit = ~flags.z;
      default:   eofHit = 1'b0;
    endcase
  end

  assign oEof         = flowEnable & eofHit;
  assign oBranchTaken = flowEnable & overwritePc;

  // ----------------------------------------------------------------------
  // Program counter
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      pc <= resetPc;
    else if (oBranchTaken)
      pc <= target;
    else if (flowEnable && uop.incPc)
      pc <= pc + 1'b1;
  end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
  import cpuPkg::*;
(
  input  wire logic   iClock,
  input  wire logic   rstN,
  input  wire logic   flowEnable,
  input  wire logic   regWe,
  input  wire regSelE writeSel,
  input  wire dataT   result,
  input  wire regSelE readSel,
  input  wire logic   setAddr,
  input  wire regSelE addrSel,
  input  wire addrT   pc,
  input  wire logic   oEof,
  output dataT        readData,
  output dataT        regA,
  output addrT        addrOut
);

  dataT       regs [0:6];   // B C D E H L A
  logic [6:0] regEn;
  regSelE     addrSelQ;

  always_comb
  begin
    regEn = '0;
    if (flowEnable && regWe && writeSel <= cpuPkg::regA)
      regEn[writeSel[2:0]] = 1'b1;
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 7; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 7; i++)
        if (regEn[i])
          regs[i] <= result;
    end
  end

  assign readData = (readSel <= cpuPkg::regA) ? regs[readSel[2:0]] : 8'h00;
  assign regA     = regs[6];

  // ----------------------------------------------------------------------
  // Memory address source
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      addrSelQ <= regPc;
    else if (oEof)
      addrSelQ <= regPc;   // Next fetch from PC
    else if (flowEnable && setAddr)
      addrSelQ <= addrSel;
  end

  always_comb
  begin
    if (addrSelQ <= cpuPkg::regA)
      addrOut = {8'h00, regs[addrSelQ[2:0]]};
    else if (addrSelQ == regHl)
      addrOut = {regs[4], regs[5]};
    else
      addrOut = pc;
  end

endmodule

`default_nettype wire

/* src/executeUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module executeUnit
  import cpuPkg::*;
(
  input  wire logic iClock,
  input  wire logic rstN,
  input  wire logic flowEnable,
  input  wire uopT  uop,
  input  wire dataT opcode,
  input  wire dataT iMemData,
  input  wire dataT readData,
  input  wire dataT regA,
  output logic      regWe,
  output regSelE    writeSel,
  output dataT      result,
  output regSelE    readSel,
  output logic      setAddr,
  output regSelE    addrSel,
  output logic      overwritePc,
  output addrT      target,
  output flagsT     flags,
  output memBusT    oMemBus
);

  aluOpE      aluOp;
  dataT       aluB;
  dataT       aluResult;
  flagsT      aluFlags;
  logic [8:0] addFull;
  logic [8:0] subFull;
  logic [4:0] addLow;
  logic [4:0] subLow;
  logic       reQ;
  addrT       tmpPc;

  // Z80 register field to register select
  // (HL) forms have flows of their own
  function automatic regSelE decodeReg(input logic [2:0] code);
    if (code == 3'd7)
      return cpuPkg::regA;
    else if (code == 3'd6)
      return regNone;
    else
      return regSelE'({1'b0, code});
  endfunction

  // ----------------------------------------------------------------------
  // Command decode
  always_comb
  begin
    regWe       = 1'b0;
    writeSel    = regNone;
    result      = 8'h00;
    readSel     = regNone;
    setAddr     = 1'b0;
    addrSel     = regPc;
    overwritePc = 1'b0;
    case (uop.cmd)
      uSetAddr:
      begin
        setAddr = 1'b1;
        addrSel = uop.operand;
      end
      uLoadMem:
      begin
        regWe    = 1'b1;
        writeSel = (uop.operand == regNone) ? decodeReg(opcode[5:3]) : uop.operand;
        result   = iMemData;
      end
      uStoreMem: readSel = uop.operand;
      uMovReg:
      begin
        regWe    = 1'b1;
        writeSel = decodeReg(opcode[5:3]);
        readSel  = decodeReg(opcode[2:0]);
        result   = readData;
      end
      uAluOp:
      begin
        regWe    = 1'b1;
        writeSel = uop.operand;
        readSel  = decodeReg(opcode[2:0]);
        result   = aluResult;
      end
      uJump: overwritePc = 1'b1;
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // ALU
  always_comb
  begin
    case (opcode[5:3])
      3'b000:  aluOp = aluAdd;
      3'b010:  aluOp = aluSub;
      3'b100:  aluOp = aluAnd;
      3'b101:  aluOp = aluXor;
      default: aluOp = aluOr;
    endcase
  end

  assign aluB    = opcode[6] ? iMemData : readData;   // Immediate form
  assign addFull = {1'b0, regA} + {1'b0, aluB};
  assign subFull = {1'b0, regA} - {1'b0, aluB};
  assign addLow  = {1'b0, regA[3:0]} + {1'b0, aluB[3:0]};
  assign subLow  = {1'b0, regA[3:0]} - {1'b0, aluB[3:0]};

  always_comb
  begin
    aluResult = regA | aluB;
    aluFlags  = '{z: 1'b0, n: 1'b0, h: 1'b0, c: 1'b0};
    case (aluOp)
      aluAdd:
      begin
        aluResult  = addFull[7:0];
        aluFlags.h = addLow[4];
        aluFlags.c = addFull[8];
      end
      aluSub:
      begin
        aluResult  = subFull[7:0];
        aluFlags.n = 1'b1;
        aluFlags.h = subLow[4];   // Borrow from bit 4
        aluFlags.c = subFull[8];
      end
      aluAnd:
      begin
        aluResult  = regA & aluB;
        aluFlags.h = 1'b1;
      end
      aluXor: aluResult = regA ^ aluB;
      aluOr:  aluResult = regA | aluB;
      default: ;
    endcase
    aluFlags.z = (aluResult == 8'h00);
  end

  always_ff @(posedge iClock)
  begin
    if (!rstN)
      flags <= '{z: 1'b1, n: 1'b0, h: 1'b1, c: 1'b1};
    else if (flowEnable && uop.cmd == uAluOp)
      flags <= aluFlags;
  end

  // Jump target assembled low byte first
  always_ff @(posedge iClock)
  begin
    if (flowEnable && uop.cmd == uLoadPcLow)
      tmpPc[7:0] <= iMemData;
    if (flowEnable && uop.cmd == uLoadPcHigh)
      tmpPc[15:8] <= iMemData;
  end

  assign target = tmpPc;

  // ----------------------------------------------------------------------
  // Bus strobes
  always_ff @(posedge iClock)
  begin
    if (!rstN)
      reQ <= 1'b0;
    else
      reQ <= flowEnable && uop.cmd == uSetAddr;
  end

  always_comb
  begin
    oMemBus.addr   = '0;   // Address comes from the register file
    oMemBus.wrData = readData;
    oMemBus.we     = flowEnable && uop.cmd == uStoreMem;
    oMemBus.re     = reQ;
  end

endmodule

`default_nettype wire

/* src/cpuCore.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCore
  import cpuPkg::*;
#(
  parameter addrT resetPc = 16'h0100
)
(
  input  wire logic iClock,
  input  wire logic rstN,
  input  wire dataT iMemData,
  output memBusT    oMemBus,
  output dataT      oCurrentInsn,
  output logic      oEof,
  output logic      oBranchTaken
);

  flowIdxT uPc;
  flowIdxT flowStart;
  uopT     uop;
  addrT    pc;
  addrT    target;
  addrT    addrOut;
  logic    flowEnable;
  logic    overwritePc;
  logic    regWe;
  logic    setAddr;
  regSelE  writeSel;
  regSelE  readSel;
  regSelE  addrSel;
  dataT    result;
  dataT    readData;
  dataT    regA;
  flagsT   flags;
  memBusT  exBus;

  // Strobes and write data from the execute unit, address from the register file
  assign oMemBus = '{addr: addrOut, wrData: exBus.wrData, we: exBus.we, re: exBus.re};

  flowSequencer #(
    .resetPc(resetPc)
  ) flowSequencer_inst (
    .iClock(iClock), .rstN(rstN), .iMemData(iMemData), .uop(uop),
    .flowStart(flowStart), .flags(flags), .overwritePc(overwritePc), .target(target),
    .uPc(uPc), .pc(pc), .opcode(oCurrentInsn), .flowEnable(flowEnable),
    .oEof(oEof), .oBranchTaken(oBranchTaken)
  );

  microcodeRom microcodeRom_inst (
    .opcode(oCurrentInsn), .uPc(uPc), .flowStart(flowStart), .uop(uop)
  );

  registerFile registerFile_inst (
    .iClock(iClock), .rstN(rstN), .flowEnable(flowEnable), .regWe(regWe),
    .writeSel(writeSel), .result(result), .readSel(readSel), .setAddr(setAddr),
    .addrSel(addrSel), .pc(pc), .oEof(oEof), .readData(readData), .regA(regA),
    .addrOut(addrOut)
  );

  executeUnit executeUnit_inst (
    .iClock(iClock), .rstN(rstN), .flowEnable(flowEnable), .uop(uop),
    .opcode(oCurrentInsn), .iMemData(iMemData), .readData(readData), .regA(regA),
    .regWe(regWe), .writeSel(writeSel), .result(result), .readSel(readSel),
    .setAddr(setAddr), .addrSel(addrSel), .overwritePc(overwritePc), .target(target),
    .flags(flags), .oMemBus(exBus)
  );

endmodule

`default_nettype wire

/* sim/progMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module progMemory
  import cpuPkg::*;
(
  input  wire logic   iClock,
  input  wire memBusT bus,
  output dataT        rdData,
  input  wire logic   loadEn,     // Program load port, used while the core is in reset
  input  wire addrT   loadAddr,
  input  wire dataT   loadData,
  input  wire logic   clearLog,
  output logic [3:0]  logCount
);

  dataT mem [0:65535];
  addrT logAddr [0:7];
  dataT logData [0:7];

  assign rdData = mem[bus.addr];   // Asynchronous read

  always @(posedge iClock)
  begin
    if (loadEn)
      mem[loadAddr] <= loadData;
    else if (bus.we)
      mem[bus.addr] <= bus.wrData;
  end

  // Write log, CPU writes only
  always @(posedge iClock)
  begin
    if (clearLog)
      logCount <= '0;
    else if (bus.we && logCount < 4'd8)
    begin
      logAddr[logCount[2:0]] <= bus.addr;
      logData[logCount[2:0]] <= bus.wrData;
      logCount <= logCount + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sim/cpuCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb
  import cpuPkg::*;
();

  typedef struct packed {
    logic  copyRow;   // LD r,r' and LD A,(HL) program instead of ALU program
    aluOpE op;
    logic  immForm;
    dataT  a;
    dataT  b;
    dataT  jpOpc;
    dataT  expResult;
    flagsT expFlags;
    logic  expBranch;
  } rowT;

  localparam int NumRows    = 31;
  localparam int CycleLimit = NumRows * 60;

  logic       iClock;
  logic       rstN;
  dataT       iMemData;
  memBusT     oMemBus;
  dataT       oCurrentInsn;
  logic       oEof;
  logic       oBranchTaken;
  logic       loadEn;
  addrT       loadAddr;
  dataT       loadData;
  logic       clearLog;
  logic [3:0] logCount;

  rowT  rows [0:NumRows-1];
  dataT progImage [addrT];
  addrT progAt;
  int   mismatches = 0;
  int   otherErrors = 0;
  int   activeCycles = 0;
  int   eofStep = 0;
  addrT fetchAddr;

  cpuCore #(
    .resetPc(16'h0100)
  ) cpuCore_inst (
    .iClock(iClock), .rstN(rstN), .iMemData(iMemData), .oMemBus(oMemBus),
    .oCurrentInsn(oCurrentInsn), .oEof(oEof), .oBranchTaken(oBranchTaken)
  );

  progMemory progMemory_inst (
    .iClock(iClock), .bus(oMemBus), .rdData(iMemData), .loadEn(loadEn),
    .loadAddr(loadAddr), .loadData(loadData), .clearLog(clearLog), .logCount(logCount)
  );

  initial
  begin
    iClock = 1'b0;
    forever #2 iClock = ~iClock;
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  task automatic checkData(input string name, input dataT got, input dataT exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkAddr(input string name, input addrT got, input addrT exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Expected values from the ALU flag rules
  function automatic logic [2:0] aluCode(input aluOpE op);
    case (op)
      aluAdd:  return 3'b000;
      aluSub:  return 3'b010;
      aluAnd:  return 3'b100;
      aluXor:  return 3'b101;
      default: return 3'b110;
    endcase
  endfunction

  function automatic rowT makeRow(input aluOpE op, input logic immForm, input dataT a,
                                  input dataT b, input dataT jpOpc);
    rowT r;
    int  sum;
    r = '0;
    r.op = op;
    r.immForm = immForm;
    r.a = a;
    r.b = b;
    r.jpOpc = jpOpc;
    sum = int'(a) + int'(b);
    case (op)
      aluAdd:
      begin
        r.expResult  = sum[7:0];
        r.expFlags.h = (int'(a[3:0]) + int'(b[3:0])) > 15;
        r.expFlags.c = sum > 255;
      end
      aluSub:
      begin
        r.expResult  = a - b;
        r.expFlags.n = 1'b1;
        r.expFlags.h = a[3:0] < b[3:0];
        r.expFlags.c = a < b;
      end
      aluAnd:
      begin
        r.expResult  = a & b;
        r.expFlags.h = 1'b1;
      end
      aluXor: r.expResult = a ^ b;
      default: r.expResult = a | b;
    endcase
    r.expFlags.z = (r.expResult == 8'h00);
    case (jpOpc)
      8'hCA:   r.expBranch = r.expFlags.z;
      8'hC2:   r.expBranch = ~r.expFlags.z;
      8'hDA:   r.expBranch = r.expFlags.c;
      default: r.expBranch = ~r.expFlags.c;
    endcase
    return r;
  endfunction

  function automatic dataT jpFor(input logic [1:0] sel);
    case (sel)
      2'd0:    return 8'hCA;
      2'd1:    return 8'hC2;
      2'd2:    return 8'hDA;
      default: return 8'hD2;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Program loading at one byte per clock while in reset
  task automatic putByte(input addrT addr, input dataT val);
    progImage[addr] = val;
    loadEn = 1'b1;
    loadAddr = addr;
    loadData = val;
    @(posedge iClock);
    #1;
    loadEn = 1'b0;
  endtask

  task automatic emit(input dataT val);
    putByte(progAt, val);
    progAt = progAt + 16'd1;
  endtask

  task automatic emitSelfLoop();
    addrT here;
    here = progAt;
    emit(8'hC3);
    emit(here[7:0]);
    emit(here[15:8]);
  endtask

  task automatic loadProgram(input rowT r);
    progAt = 16'h0100;
    if (r.copyRow)
    begin
      emit(8'h06);
      emit(r.b);
      emit(8'h50);   // LD D,B
      emit(8'h76);   // HALT runs the NOP flow
      emit(8'h26);
      emit(8'hC0);
      emit(8'h2E);
      emit(8'h10);
      emit(8'h7E);   // LD A,(HL)
      emit(8'h2E);
      emit(8'h01);
      emit(8'h77);
      emit(8'h7A);   // LD A,D
      emit(8'h2E);
      emit(8'h03);
      emit(8'h77);
      emitSelfLoop();
      putByte(16'hC010, r.a);
    end
    else
    begin
      emit(8'h3E);
      emit(r.a);
      emit(8'h06);
      emit(r.b);
      if (r.immForm)
      begin
        emit(8'hC6 | {2'b00, aluCode(r.op), 3'b000});
        emit(r.b);
      end
      else
        emit(8'h80 | {2'b00, aluCode(r.op), 3'b000});
      emit(8'h26);
      emit(8'hC0);
      emit(8'h2E);
      emit(8'h01);
      emit(8'h77);
      emit(r.jpOpc);
      emit(8'h00);
      emit(8'h02);
      emit(8'h2E);
      emit(8'h02);
      emit(8'h77);
      emitSelfLoop();
      progAt = 16'h0200;   // Jump target T
      emit(8'h2E);
      emit(8'h03);
      emit(8'h77);
      emitSelfLoop();
    end
  endtask

  // ----------------------------------------------------------------------
  task automatic runRow(input int idx);
    rowT  r;
    int   branches;
    addrT wantAddr;
    r = rows[idx];
    rstN = 1'b0;
    clearLog = 1'b1;
    @(posedge iClock);
    #1;
    clearLog = 1'b0;
    progImage.delete();
    loadProgram(r);
    repeat (16)
    begin
      @(negedge iClock);
      checkFlag("oMemBus.we in reset", oMemBus.we, 1'b0);
      checkFlag("oMemBus.re in reset", oMemBus.re, 1'b0);
      checkFlag("oEof in reset", oEof, 1'b0);
      checkFlag("oBranchTaken in reset", oBranchTaken, 1'b0);
      @(posedge iClock);
      #1;
    end
    rstN = 1'b1;
    @(negedge iClock);
    checkFlag("oMemBus.we after reset", oMemBus.we, 1'b0);
    checkFlag("oMemBus.re after reset", oMemBus.re, 1'b0);
    checkFlag("oEof after reset", oEof, 1'b0);
    checkFlag("oBranchTaken after reset", oBranchTaken, 1'b0);
    checkAddr("oMemBus.addr after reset", oMemBus.addr, 16'h0100);
    branches = 0;
    while (logCount < 4'd2)
    begin
      @(negedge iClock);
      if (oBranchTaken)
        branches++;
    end
    wantAddr = (r.copyRow || r.expBranch) ? 16'hC003 : 16'hC002;
    checkAddr("first write addr", progMemory_inst.logAddr[0], 16'hC001);
    checkData("first write data", progMemory_inst.logData[0],
              r.copyRow ? r.a : r.expResult);
    checkAddr("second write addr", progMemory_inst.logAddr[1], wantAddr);
    checkData("second write data", progMemory_inst.logData[1],
              r.copyRow ? r.b : r.expResult);
    checkFlag("oBranchTaken pulse", branches != 0, r.expBranch);
    if (branches > 1)
    begin
      $display("Row %0d: the branch pulse came %0d times for one jump", idx, branches);
      otherErrors++;
    end
    checkFlag("flags.z", cpuCore_inst.flags.z, r.expFlags.z);
    checkFlag("flags.n", cpuCore_inst.flags.n, r.expFlags.n);
    checkFlag("flags.h", cpuCore_inst.flags.h, r.expFlags.h);
    checkFlag("flags.c", cpuCore_inst.flags.c, r.expFlags.c);
    repeat (3) @(negedge iClock);   // Let the fetch monitor finish
    @(posedge iClock);
    #1;
  endtask

  // Opcode latched after each oEof must be the byte fetched at the PC
  always @(negedge iClock)
  begin
    if (!rstN)
      eofStep = 0;
    else
    begin
      if (eofStep == 1)
      begin
        if (!progImage.exists(fetchAddr))
        begin
          $display("Fetch at %0t from address %h outside the loaded program", $time, fetchAddr);
          otherErrors++;
        end
        else
          checkData("oCurrentInsn", oCurrentInsn, progImage[fetchAddr]);
        eofStep = 0;
      end
      else if (eofStep == 2)
      begin
        fetchAddr = oMemBus.addr;   // startFlow
        eofStep = 1;
      end
      else if (eofStep == 3)
        eofStep = 2;
      if (oEof)
        eofStep = 3;
    end
  end

  always @(posedge iClock)
  begin
    if (rstN)
      activeCycles++;
    if (activeCycles > CycleLimit)
    begin
      $display("Timeout, the programs did not finish within %0d cycles", CycleLimit);
      $display("%0d mismatches, %0d other errors", mismatches, otherErrors + 1);
      $display("Something failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  initial
  begin
    int          seed;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    int          opIdx;
    rstN = 1'b0;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = '0;
    clearLog = 1'b0;
    rows[0]  = makeRow(aluAdd, 1'b0, 8'h3C, 8'h0F, 8'hDA);
    rows[1]  = makeRow(aluAdd, 1'b1, 8'hF0, 8'h10, 8'hCA);
    rows[2]  = makeRow(aluSub, 1'b0, 8'h10, 8'h20, 8'hD2);
    rows[3]  = makeRow(aluSub, 1'b1, 8'h45, 8'h45, 8'hC2);
    rows[4]  = makeRow(aluAnd, 1'b0, 8'hF0, 8'h0F, 8'hCA);
    rows[5]  = makeRow(aluAnd, 1'b1, 8'h5A, 8'h3C, 8'hD2);
    rows[6]  = makeRow(aluXor, 1'b0, 8'hAA, 8'hAA, 8'hC2);
    rows[7]  = makeRow(aluXor, 1'b1, 8'h81, 8'h7E, 8'hDA);
    rows[8]  = makeRow(aluOr, 1'b0, 8'h00, 8'h00, 8'hCA);
    rows[9]  = makeRow(aluOr, 1'b1, 8'h12, 8'h40, 8'hC2);
    rows[10] = '0;
    rows[10].copyRow  = 1'b1;
    rows[10].a        = 8'hA5;   // Seeded byte at C010h
    rows[10].b        = 8'h3E;
    rows[10].expFlags = '{z: 1'b1, n: 1'b0, h: 1'b1, c: 1'b1};
    seed = 72621;
    for (int i = 11; i < NumRows; i++)
    begin
      rnd = $random(seed);
      rnd2 = $random(seed);
      opIdx = int'(rnd[15:0]) % 5;
      rows[i] = makeRow(aluOpE'(opIdx[2:0]), rnd[16], rnd2[7:0], rnd2[15:8],
                        jpFor(rnd[18:17]));
    end
    @(posedge iClock);
    #1;
    for (int i = 0; i < NumRows; i++)
      runRow(i);
    $display("%0d mismatches, %0d other errors", mismatches, otherErrors);
    if (mismatches == 0 && otherErrors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/cpuPkg.sv
src/microcodeRom.sv
src/flowSequencer.sv
src/registerFile.sv
src/executeUnit.sv
src/cpuCore.sv
sim/progMemory.sv
sim/cpuCoreTb.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module cpuCoreTb -o simv

run: compile
	./obj_dir/simv | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
